// File: Makefile
# Verilator simulation of the board glue testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
board_pkg.sv
pad_pkg.sv
board_rst_sync.sv
board_boot_sel.sv
board_rtc_div.sv
board_fan_pwm.sv
board_top_fpga.sv
tb_board_top.sv

// File: board_boot_sel.sv
//////////////////////////////
// Boot mode selection for the SoC boot pins
// Follows switches or debug override in reset, then freezes the choice
//////////////////////////////

`timescale 1ns/1ps

module board_boot_sel (
  input  logic                   soc_clk,
  input  logic                   rst_n,
  input  board_pkg::boot_mode_e  boot_mode_i,
  input  logic                   dbg_boot_sel_i,
  input  board_pkg::boot_mode_e  dbg_boot_mode_i,
  output board_pkg::boot_mode_e  boot_mode_o
);

  import board_pkg::*;

  boot_state_e state_q;
  boot_mode_e  mode_live;
  boot_mode_e  mode_q;

  // Debug override wins over the switches
  assign mode_live = dbg_boot_sel_i ? dbg_boot_mode_i : boot_mode_i;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= BOOT_WAIT;
    end else begin
      unique case (state_q)
        BOOT_WAIT: state_q <= BOOT_HOLD;
        BOOT_HOLD: state_q <= BOOT_HOLD;
        default:   state_q <= BOOT_WAIT;
      endcase
    end
  end

  // Tracks the live value until the first cycle out of reset
  always_ff @(posedge soc_clk) begin
    if (state_q == BOOT_WAIT) begin
      mode_q <= mode_live;
    end
  end

  // Live in reset, latched afterwards
  assign boot_mode_o = (state_q == BOOT_HOLD) ? mode_q : mode_live;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Switch and override changes must not reach the SoC once running
  assert property (@(posedge soc_clk) disable iff (!rst_n)
    (state_q == BOOT_HOLD) |=> $stable(boot_mode_o))
    else $error("boot_mode_o changed after reset release");

endmodule

// File: board_fan_pwm.sv
//////////////////////////////
// Fan PWM drive from a 4-bit speed setting
// Gives a full-on kick when the fan starts from off
//////////////////////////////

`timescale 1ns/1ps

module board_fan_pwm (
  input  logic       soc_clk,
  input  logic       rst_n,
  input  logic [3:0] fan_setting_i,
  output logic       fan_pwm_o
);

  import board_pkg::*;

  logic [FanPreWidth-1:0]  pre_q, pre_d;
  logic [FanSlotWidth-1:0] slot_q, slot_d;
  logic [FanKickWidth-1:0] kick_q, kick_d;
  logic [3:0]              setting_q, setting_d;
  fan_state_e              state_q, state_d;
  logic                    pre_wrap;
  logic                    period_end;
  logic                    pwm_q, pwm_d;

  assign pre_wrap   = (pre_q == FanPreWidth'(FanPrescale - 1));
  assign period_end = pre_wrap && (slot_q == FanSlotWidth'(FanSlots - 1));

  always_comb begin
    pre_d     = pre_q + 1'b1;
    slot_d    = slot_q;
    kick_d    = kick_q;
    setting_d = setting_q;
    state_d   = state_q;

    // Slot timebase
    if (pre_wrap) begin
      pre_d  = '0;
      slot_d = period_end ? '0 : slot_q + 1'b1;
    end

    // Setting and state only move at a period boundary
    if (period_end) begin
      setting_d = fan_setting_i;
      unique case (state_q)
        FAN_OFF: begin
          if (fan_setting_i != 4'd0) begin
            state_d = FAN_KICK;
            kick_d  = '0;
          end
        end
        FAN_KICK: begin
          if (fan_setting_i == 4'd0) begin
            state_d = FAN_OFF;
          end else if (kick_q == FanKickWidth'(FanKickPeriods - 1)) begin
            state_d = FAN_RUN;
          end else begin
            kick_d = kick_q + 1'b1;
          end
        end
        FAN_RUN: begin
          if (fan_setting_i == 4'd0) begin
            state_d = FAN_OFF;
          end
        end
        default: state_d = FAN_OFF;
      endcase
    end

    // Output for the coming cycle
    unique case (state_d)
      FAN_KICK: pwm_d = 1'b1;
      FAN_RUN:  pwm_d = (4'(slot_d) < setting_d);
      default:  pwm_d = 1'b0;
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q   <= '0;
      slot_q  <= '0;
      kick_q  <= '0;
      state_q <= FAN_OFF;
      pwm_q   <= 1'b0;
    end else begin
      pre_q   <= pre_d;
      slot_q  <= slot_d;
      kick_q  <= kick_d;
      state_q <= state_d;
      pwm_q   <= pwm_d;
    end
  end

  always_ff @(posedge soc_clk) begin
    setting_q <= setting_d;
  end

  assign fan_pwm_o = pwm_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge soc_clk) disable iff (!rst_n)
    (state_q == FAN_OFF) |-> !fan_pwm_o)
    else $error("fan driven while off");

  assert property (@(posedge soc_clk) disable iff (!rst_n)
    (state_q == FAN_KICK) |-> fan_pwm_o)
    else $error("fan not full on during kick");

endmodule

// File: board_pkg.sv
//////////////////////////////
// Timing constants and state types for the board glue blocks
// Import into the body of any block that counts or holds state
//////////////////////////////

package board_pkg;

  // Reset synchronizer depth
  localparam int unsigned RstSyncStages = 2;

  // RTC is soc_clk divided by twice this value
  localparam int unsigned RtcHalfPeriod = 25;
  localparam int unsigned RtcCntWidth   = $clog2(RtcHalfPeriod);

  // Fan PWM period is FanPrescale * FanSlots cycles
  localparam int unsigned FanPrescale    = 4;
  localparam int unsigned FanSlots       = 16;
  localparam int unsigned FanKickPeriods = 4;
  localparam int unsigned FanPreWidth    = $clog2(FanPrescale);
  localparam int unsigned FanSlotWidth   = $clog2(FanSlots);
  localparam int unsigned FanKickWidth   = $clog2(FanKickPeriods);

  // Boot source seen by the SoC on its boot pins
  typedef enum logic [1:0] {
    BOOT_PASSIVE   = 2'd0,
    BOOT_SPI_SD    = 2'd1,
    BOOT_SPI_FLASH = 2'd2,
    BOOT_UART      = 2'd3
  } boot_mode_e;

  typedef enum logic {
    BOOT_WAIT,
    BOOT_HOLD
  } boot_state_e;

  typedef enum logic [1:0] {
    FAN_OFF,
    FAN_KICK,
    FAN_RUN
  } fan_state_e;

endpackage

// File: board_rst_sync.sv
//////////////////////////////
// SoC reset generator
// Asserts asynchronously on board or debug reset, releases on soc_clk
//////////////////////////////

`timescale 1ns/1ps

module board_rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic dbg_rst_i,
  input  logic test_mode_i,
  output logic soc_rst_no
);

  import board_pkg::*;

  logic                     rst_src_n;
  logic [RstSyncStages-1:0] sync_q;

  // Either source holds the SoC in reset
  assign rst_src_n = rst_n & ~dbg_rst_i;

  // Ones shift in after both sources are released
  always_ff @(posedge soc_clk or negedge rst_src_n) begin
    if (!rst_src_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[RstSyncStages-2:0], 1'b1};
    end
  end

  // Test mode hands the board reset straight through
  assign soc_rst_no = test_mode_i ? rst_n : sync_q[RstSyncStages-1];

  //////////////////////////////
  // Checks
  //////////////////////////////

  // SoC must not leave reset while the board reset is held
  assert property (@(posedge soc_clk) $rose(soc_rst_no) |-> rst_n)
    else $error("soc_rst_no released while rst_n is low");

endmodule

// File: board_rtc_div.sv
//////////////////////////////
// Real-time clock for the SoC
// Registered divide of soc_clk by 2 * RtcHalfPeriod
//////////////////////////////

`timescale 1ns/1ps

module board_rtc_div (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  import board_pkg::*;

  logic [RtcCntWidth-1:0] cnt_q;
  logic                   cnt_wrap;
  logic                   rtc_q;

  assign cnt_wrap = (cnt_q == RtcCntWidth'(RtcHalfPeriod - 1));

  // Half period counter, toggle on wrap
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_wrap) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = rtc_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge soc_clk) disable iff (!rst_n)
    cnt_q <= RtcCntWidth'(RtcHalfPeriod - 1))
    else $error("RTC counter beyond wrap value");

endmodule

// File: board_top_fpga.sv
//////////////////////////////
// Board glue top level for the FPGA prototype
// Sits between the board pins and the SoC-side ports
// Holds reset, boot mode, RTC, fan drive and SD pad mapping
//////////////////////////////

`timescale 1ns/1ps

module board_top_fpga (
  input  logic                  soc_clk,
  input  logic                  rst_n,

  // Board switches and debug controls
  input  logic                  test_mode_i,
  input  logic                  dbg_rst_i,
  input  board_pkg::boot_mode_e boot_mode_i,
  input  logic                  dbg_boot_sel_i,
  input  board_pkg::boot_mode_e dbg_boot_mode_i,
  input  logic [3:0]            fan_setting_i,

  // SPI host from the SoC and SD card data in
  input  pad_pkg::spi_host_t    spi_host_i,
  input  logic                  sd_dat0_i,

  // To the SoC
  output logic                  soc_rst_no,
  output board_pkg::boot_mode_e boot_mode_o,
  output logic                  rtc_o,
  output logic                  spi_miso_o,

  // To the board
  output logic                  fan_pwm_o,
  output pad_pkg::sd_pads_t     sd_pads_o
);

  logic soc_rst_n;

  //////////////////////////////
  // Reset
  //////////////////////////////

  board_rst_sync i_rst_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .dbg_rst_i   ( dbg_rst_i   ),
    .test_mode_i ( test_mode_i ),
    .soc_rst_no  ( soc_rst_n   )
  );

  assign soc_rst_no = soc_rst_n;

  //////////////////////////////
  // Boot mode and timers
  //////////////////////////////

  board_boot_sel i_boot_sel (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( soc_rst_n       ),
    .boot_mode_i     ( boot_mode_i     ),
    .dbg_boot_sel_i  ( dbg_boot_sel_i  ),
    .dbg_boot_mode_i ( dbg_boot_mode_i ),
    .boot_mode_o     ( boot_mode_o     )
  );

  board_rtc_div i_rtc_div (
    .soc_clk ( soc_clk   ),
    .rst_n   ( soc_rst_n ),
    .rtc_o   ( rtc_o     )
  );

  board_fan_pwm i_fan_pwm (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( soc_rst_n     ),
    .fan_setting_i ( fan_setting_i ),
    .fan_pwm_o     ( fan_pwm_o     )
  );

  //////////////////////////////
  // SPI onto SD pads
  //////////////////////////////

  // Undriven SPI lines idle high on the card side
  assign sd_pads_o.sclk     = spi_host_i.sck_en    ? spi_host_i.sck    : 1'b1;
  // Chip select 0 on DAT3
  assign sd_pads_o.dat3     = spi_host_i.csb_en[0] ? spi_host_i.csb[0] : 1'b1;
  // MOSI on CMD
  assign sd_pads_o.cmd      = spi_host_i.sd_en[0]  ? spi_host_i.sd[0]  : 1'b1;
  // DAT1 and DAT2 unused in SPI mode
  assign sd_pads_o.dat2_1   = 2'b11;
  // Card stays powered
  assign sd_pads_o.card_rst = 1'b0;

  // MISO comes back on DAT0
  assign spi_miso_o = sd_dat0_i;

endmodule

// File: pad_pkg.sv
//////////////////////////////
// Signal bundles between the SoC SPI host and the SD-card pads
// Used as port types on the board top level
//////////////////////////////

package pad_pkg;

  // SPI host outputs from the SoC, 14 bits
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd;
    logic [3:0] sd_en;
  } spi_host_t;

  // SD-card pad outputs in SPI mode, 6 bits
  typedef struct packed {
    // Card clock
    logic       sclk;
    // Command line, carries MOSI
    logic       cmd;
    // Chip select on DAT3
    logic       dat3;
    // Unused data lines, pulled high
    logic [1:0] dat2_1;
    // Low keeps the card powered
    logic       card_rst;
  } sd_pads_t;

endpackage

// File: tb_board_top.sv
//////////////////////////////
// Directed testbench for the board glue top level
// Runs reset, boot, RTC, fan and SD pad tests in turn
//////////////////////////////

`timescale 1ns/1ps

module tb_board_top;

  import board_pkg::*;
  import pad_pkg::*;

  localparam int FanPeriod  = FanPrescale * FanSlots;
  localparam int NumFanRuns = 8;
  localparam int NumSdVecs  = 32;
  localparam int RtcChecked = 8 * RtcHalfPeriod;
  // Reset, boot and RTC tests, then fan periods, then SD vectors
  localparam int TestCycles = 16 + 100 + RtcChecked + 20
                              + FanPeriod * (FanKickPeriods + NumFanRuns + 5) + NumSdVecs;
  localparam int MaxCycles  = 2 * TestCycles;

  logic       soc_clk;
  logic       rst_n;
  logic       test_mode_i;
  logic       dbg_rst_i;
  boot_mode_e boot_mode_i;
  logic       dbg_boot_sel_i;
  boot_mode_e dbg_boot_mode_i;
  logic [3:0] fan_setting_i;
  spi_host_t  spi_host_i;
  logic       sd_dat0_i;
  logic       soc_rst_no;
  boot_mode_e boot_mode_o;
  logic       rtc_o;
  logic       fan_pwm_o;
  sd_pads_t   sd_pads_o;
  logic       spi_miso_o;

  integer     seed;
  int         err_cnt = 0;
  int         chk_cnt = 0;
  int         cyc_cnt = 0;
  // Rising edges since soc_rst_no went high
  int         rel_cyc = 0;

  board_top_fpga i_dut (.*);

  always #2 soc_clk = ~soc_clk;

  always @(posedge soc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= MaxCycles) begin
      $display("Timeout: tests still running after %0d cycles", MaxCycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  always @(posedge soc_clk) begin
    rel_cyc <= soc_rst_no ? rel_cyc + 1 : 0;
  end

  //////////////////////////////
  // Compare tasks and models
  //////////////////////////////

  task automatic compare_logic(input string name, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic compare_boot(input string name, input boot_mode_e exp, input boot_mode_e act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %0t: %s expected %s got %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic compare_sd(input string name, input sd_pads_t exp, input sd_pads_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    chk_cnt++;
    if (act != exp) begin
      err_cnt++;
      $display("ERROR %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // Debug override wins over the switches
  function automatic boot_mode_e live_boot();
    return dbg_boot_sel_i ? dbg_boot_mode_i : boot_mode_i;
  endfunction

  // Pads idle high unless the host enables them
  function automatic sd_pads_t expected_sd(input spi_host_t h);
    sd_pads_t p;
    p.sclk     = h.sck_en ? h.sck : 1'b1;
    p.cmd      = h.sd_en[0] ? h.sd[0] : 1'b1;
    p.dat3     = h.csb_en[0] ? h.csb[0] : 1'b1;
    p.dat2_1   = 2'b11;
    p.card_rst = 1'b0;
    return p;
  endfunction

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic release_reset();
    @(negedge soc_clk);
    rst_n = 1'b1;
    do begin
      @(negedge soc_clk);
    end while (!soc_rst_no);
  endtask

  // Stops on the falling edge at a given phase of the fan period
  task automatic wait_phase(input int phase);
    do begin
      @(negedge soc_clk);
    end while (rel_cyc % FanPeriod != phase);
  endtask

  task automatic count_high(output int highs);
    highs = 0;
    for (int i = 0; i < FanPeriod; i++) begin
      @(negedge soc_clk);
      if (fan_pwm_o) begin
        highs++;
      end
    end
  endtask

  task automatic check_reset_source(input logic use_dbg);
    @(negedge soc_clk);
    // Debug reset high, or board reset low
    rst_n     = use_dbg;
    dbg_rst_i = use_dbg;
    #1;
    compare_logic("soc_rst_no", 1'b0, soc_rst_no);
    repeat (3) @(negedge soc_clk);
    rst_n     = 1'b1;
    dbg_rst_i = 1'b0;
    @(negedge soc_clk);
    compare_logic("soc_rst_no", 1'b0, soc_rst_no);
    @(negedge soc_clk);
    compare_logic("soc_rst_no", 1'b1, soc_rst_no);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_sync();
    check_reset_source(1'b0);
    check_reset_source(1'b1);
    // Test mode passes rst_n straight through
    @(negedge soc_clk);
    test_mode_i = 1'b1;
    rst_n       = 1'b0;
    #1;
    compare_logic("soc_rst_no", 1'b0, soc_rst_no);
    @(negedge soc_clk);
    rst_n = 1'b1;
    #1;
    compare_logic("soc_rst_no", 1'b1, soc_rst_no);
    repeat (4) @(negedge soc_clk);
    test_mode_i = 1'b0;
    #1;
    compare_logic("soc_rst_no", 1'b1, soc_rst_no);
  endtask

  task automatic test_boot_latch();
    logic [31:0] tmp;
    boot_mode_e  held;
    @(negedge soc_clk);
    rst_n = 1'b0;
    for (int i = 0; i < 6; i++) begin
      @(negedge soc_clk);
      tmp             = $random(seed);
      boot_mode_i     = boot_mode_e'(tmp[1:0]);
      dbg_boot_mode_i = boot_mode_e'(tmp[3:2]);
      dbg_boot_sel_i  = tmp[4];
      #1;
      compare_boot("boot_mode_o", live_boot(), boot_mode_o);
    end
    held = live_boot();
    release_reset();
    // Capture edge is the first one with reset released
    @(negedge soc_clk);
    for (int i = 0; i < 8; i++) begin
      tmp             = $random(seed);
      boot_mode_i     = boot_mode_e'(tmp[1:0]);
      dbg_boot_mode_i = boot_mode_e'(tmp[3:2]);
      dbg_boot_sel_i  = tmp[4];
      @(negedge soc_clk);
      compare_boot("boot_mode_o", held, boot_mode_o);
    end
    rst_n = 1'b0;
    #1;
    compare_boot("boot_mode_o", live_boot(), boot_mode_o);
    release_reset();
  endtask

  task automatic test_rtc();
    @(negedge soc_clk);
    rst_n = 1'b0;
    repeat (2) begin
      @(negedge soc_clk);
      compare_logic("rtc_o", 1'b0, rtc_o);
    end
    release_reset();
    // k counts rising edges since soc_rst_no rose
    for (int k = 0; k < RtcChecked; k++) begin
      if (k > 0) begin
        @(negedge soc_clk);
      end
      compare_logic("rtc_o", 1'((k / RtcHalfPeriod) % 2), rtc_o);
    end
  endtask

  // Ends on the last falling edge of a period
  task automatic test_fan_kick();
    logic [31:0] tmp;
    logic [3:0]  setting;
    int          highs;
    tmp     = $random(seed);
    setting = (tmp[3:0] == 4'd0) ? 4'd5 : tmp[3:0];
    wait_phase(FanPeriod - 1);
    count_high(highs);
    compare_count("fan_pwm_o high cycles", 0, highs);
    fan_setting_i = setting;
    for (int i = 0; i < FanKickPeriods * FanPeriod; i++) begin
      @(negedge soc_clk);
      compare_logic("fan_pwm_o", 1'b1, fan_pwm_o);
    end
    count_high(highs);
    compare_count("fan_pwm_o high cycles", int'(FanPrescale * setting), highs);
  endtask

  // Starts on the last falling edge of a period with the fan running
  task automatic test_fan_pwm();
    logic [31:0] tmp;
    logic [3:0]  setting;
    int          highs;
    for (int n = 0; n < NumFanRuns; n++) begin
      tmp           = $random(seed);
      setting       = (tmp[3:0] == 4'd0) ? 4'd1 : tmp[3:0];
      fan_setting_i = setting;
      count_high(highs);
      compare_count("fan_pwm_o high cycles", int'(FanPrescale * setting), highs);
    end
    fan_setting_i = 4'd0;
    repeat (2) begin
      count_high(highs);
      compare_count("fan_pwm_o high cycles", 0, highs);
    end
  endtask

  task automatic test_sd_pads();
    logic [31:0] tmp;
    for (int i = 0; i < NumSdVecs; i++) begin
      @(negedge soc_clk);
      tmp        = $random(seed);
      spi_host_i = spi_host_t'(tmp[13:0]);
      sd_dat0_i  = tmp[20];
      // Every other vector with the host fully idle
      if (i % 2 == 1) begin
        spi_host_i.sck_en = 1'b0;
        spi_host_i.csb_en = 2'b00;
        spi_host_i.sd_en  = 4'b0000;
      end
      @(posedge soc_clk);
      compare_sd("sd_pads_o", expected_sd(spi_host_i), sd_pads_o);
      compare_logic("spi_miso_o", sd_dat0_i, spi_miso_o);
    end
  endtask

  initial begin
    seed            = 32'ha0b3;
    soc_clk         = 1'b0;
    rst_n           = 1'b0;
    test_mode_i     = 1'b0;
    dbg_rst_i       = 1'b0;
    boot_mode_i     = BOOT_PASSIVE;
    dbg_boot_sel_i  = 1'b0;
    dbg_boot_mode_i = BOOT_PASSIVE;
    fan_setting_i   = 4'd0;
    spi_host_i      = '0;
    sd_dat0_i       = 1'b0;
    repeat (16) @(posedge soc_clk);
    release_reset();
    test_reset_sync();
    test_boot_latch();
    test_rtc();
    test_fan_kick();
    test_fan_pwm();
    test_sd_pads();
    $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
